/* Bender.yml */
package:
  name: calc

sources:
  - include_dirs:
      - include
    files:
      - src/calc_pkg.sv
      - src/add_sub_unit.sv
      - src/shift_add_multiplier.sv
      - src/calc_controller.sv
      - src/calc_top.sv
      - target: test
        files:
          - verif/calc_properties.sv
          - verif/calc_checker.sv
          - verif/tb_calc.sv

/* flist.f */
+incdir+include
src/calc_pkg.sv
src/add_sub_unit.sv
src/shift_add_multiplier.sv
src/calc_controller.sv
src/calc_top.sv
verif/calc_properties.sv
verif/calc_checker.sv
verif/tb_calc.sv

/* include/calc_defines.svh */
`ifndef CALC_DEFINES_SVH
`define CALC_DEFINES_SVH

// Datapath width, all arithmetic wraps modulo 2^CALC_WIDTH
`define CALC_WIDTH 16

`define DIGIT_WIDTH 4                  // One keypad digit
`define MAX_DIGIT   9                  // Codes above this are ignored

`define OP_WIDTH 3                     // One-hot operator code
`define OP_ADD   3'b001
`define OP_SUB   3'b010
`define OP_MUL   3'b100

`endif

/* src/add_sub_unit.sv */
`include "calc_defines.svh"

module add_sub_unit import calc_pkg::*; #(
    parameter int SLICE_WIDTH = 4
) (
    input  logic  clk,
    input  logic  nRST,
    input  logic  as_start,
    input  word_t as_a,
    input  word_t as_b,
    input  logic  as_sub,
    output word_t as_result,
    output logic  as_done
);
    localparam int NUM_SLICES = `CALC_WIDTH / SLICE_WIDTH;
    localparam int CNT_W      = (NUM_SLICES > 1) ? $clog2(NUM_SLICES) : 1;

    word_t                  a_q, b_q, res_q;
    word_t                  b_in, a_src, b_src;
    logic                   carry_q, active_q, done_q;
    logic [CNT_W-1:0]       left_q;            // Slices still to add
    logic [SLICE_WIDTH:0]   slice_sum;
    logic                   cin, step, last;

    // The start cycle already adds slice 0 straight from the inputs
    always_comb begin
        b_in      = as_sub ? ~as_b : as_b;     // Two's complement with cin
        a_src     = as_start ? as_a : a_q;
        b_src     = as_start ? b_in : b_q;
        cin       = as_start ? as_sub : carry_q;
        slice_sum = {1'b0, a_src[SLICE_WIDTH-1:0]} + {1'b0, b_src[SLICE_WIDTH-1:0]}
                  + {{SLICE_WIDTH{1'b0}}, cin};
    end

    assign step = as_start || active_q;
    assign last = as_start ? (NUM_SLICES == 1) : (left_q == CNT_W'(1));

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            active_q <= 1'b0;
            done_q   <= 1'b0;
            left_q   <= '0;
        end else begin
            active_q <= step && !last;
            done_q   <= step && last;          // Single cycle pulse
            if (step)
                left_q <= as_start ? CNT_W'(NUM_SLICES - 1) : left_q - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (step) begin
            a_q     <= a_src >> SLICE_WIDTH;
            b_q     <= b_src >> SLICE_WIDTH;
            carry_q <= slice_sum[SLICE_WIDTH];   // Ripple into next slice
            res_q   <= {slice_sum[SLICE_WIDTH-1:0], res_q[`CALC_WIDTH-1:SLICE_WIDTH]};
        end
    end

    assign as_result = res_q;
    assign as_done   = done_q;

endmodule

/* src/calc_controller.sv */
`include "calc_defines.svh"

module calc_controller import calc_pkg::*; (
    input  logic   clk,
    input  logic   nRST,
    input  digit_t key_digit,
    input  logic   key_valid,
    input  op_t    op_code,
    input  logic   op_valid,
    input  logic   equal,
    output logic   busy,
    output logic   complete,
    output word_t  display,
    output word_t  as_a,
    output word_t  as_b,
    output logic   as_sub,
    output logic   as_start,
    input  word_t  as_result,
    input  logic   as_done,
    output word_t  mul_a,
    output word_t  mul_b,
    output logic   mul_start,
    input  word_t  mul_result,
    input  logic   mul_done
);
    typedef enum logic [2:0] {
        GET_FIRST   = 3'd0,
        GET_SECOND  = 3'd1,
        SCALE_WAIT  = 3'd2,                    // Operand times ten on multiplier
        CALC_WAIT   = 3'd3,
        SHOW_RESULT = 3'd4
    } calc_state_e;

    calc_state_e state_q, state_d;

    word_t  operand_a, operand_b;
    op_t    op_q;
    digit_t digit_q;
    logic   scale_second;                      // Digit belongs to operand b

    logic   entry_state;
    logic   digit_ok, op_ok;
    logic   accept_digit, accept_op, dispatch, unit_done;

    // SHOW_RESULT is not busy, so it takes the next entry like GET_FIRST
    assign entry_state  = (state_q == GET_FIRST) || (state_q == GET_SECOND)
                       || (state_q == SHOW_RESULT);
    assign digit_ok     = (key_digit <= `DIGIT_WIDTH'(`MAX_DIGIT));
    assign op_ok        = (op_code == `OP_ADD) || (op_code == `OP_SUB)
                       || (op_code == `OP_MUL);

    assign accept_digit = key_valid && digit_ok && entry_state;
    assign accept_op    = !accept_digit && op_valid && op_ok
                       && (state_q == GET_FIRST || state_q == SHOW_RESULT);
    assign dispatch     = !accept_digit && equal && (state_q == GET_SECOND);
    assign unit_done    = as_done || mul_done;

    always_comb begin
        state_d = state_q;
        case (state_q)
            GET_FIRST, GET_SECOND, SHOW_RESULT: begin
                if (accept_digit)
                    state_d = SCALE_WAIT;
                else if (accept_op)
                    state_d = GET_SECOND;
                else if (dispatch)
                    state_d = CALC_WAIT;
                else if (state_q == SHOW_RESULT)
                    state_d = GET_FIRST;
            end
            SCALE_WAIT: begin
                if (mul_done)
                    state_d = scale_second ? GET_SECOND : GET_FIRST;
            end
            CALC_WAIT: begin
                if (unit_done)
                    state_d = SHOW_RESULT;
            end
            default: state_d = GET_FIRST;
        endcase
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state_q      <= GET_FIRST;
            operand_a    <= '0;
            operand_b    <= '0;
            op_q         <= `OP_ADD;
            scale_second <= 1'b0;
            display      <= '0;
            as_start     <= 1'b0;
            mul_start    <= 1'b0;
        end else begin
            state_q   <= state_d;
            as_start  <= dispatch && (op_q != `OP_MUL);
            mul_start <= accept_digit || (dispatch && (op_q == `OP_MUL));

            if (accept_digit)
                scale_second <= (state_q == GET_SECOND);
            if (accept_op)
                op_q <= op_code;

            // New operand value is product plus the held digit
            if (state_q == SCALE_WAIT && mul_done) begin
                if (scale_second)
                    operand_b <= mul_result + word_t'(digit_q);
                else
                    operand_a <= mul_result + word_t'(digit_q);
            end

            if (state_q == CALC_WAIT && unit_done) begin
                display   <= as_done ? as_result : mul_result;
                operand_a <= '0;               // Ready for the next entry
                operand_b <= '0;
            end
        end
    end

    // Unit operands, held until the unit reports done
    always_ff @(posedge clk) begin
        if (accept_digit) begin
            digit_q <= key_digit;
            mul_a   <= (state_q == GET_SECOND) ? operand_b : operand_a;
            mul_b   <= word_t'(10);
        end else if (dispatch) begin
            as_a   <= operand_a;
            as_b   <= operand_b;
            as_sub <= (op_q == `OP_SUB);
            mul_a  <= operand_a;
            mul_b  <= operand_b;
        end
    end

    assign busy     = (state_q == SCALE_WAIT) || (state_q == CALC_WAIT);
    assign complete = (state_q == SHOW_RESULT);

endmodule

/* src/calc_pkg.sv */
`include "calc_defines.svh"

package calc_pkg;

    // Operand and result word
    typedef logic [`CALC_WIDTH-1:0] word_t;

    typedef logic [`DIGIT_WIDTH-1:0] digit_t;    // Keypad digit code

    typedef logic [`OP_WIDTH-1:0] op_t;          // One-hot operator

endpackage

/* src/calc_top.sv */
module calc_top import calc_pkg::*; (
    input  logic   clk,
    input  logic   nRST,
    input  digit_t key_digit,
    input  logic   key_valid,
    input  op_t    op_code,
    input  logic   op_valid,
    input  logic   equal,
    output logic   busy,
    output logic   complete,
    output word_t  display
);
    word_t as_a, as_b, as_result;
    logic  as_sub, as_start, as_done;
    word_t mul_a, mul_b, mul_result;
    logic  mul_start, mul_done;

    calc_controller u_ctrl (
        .clk        (clk),
        .nRST       (nRST),
        .key_digit  (key_digit),
        .key_valid  (key_valid),
        .op_code    (op_code),
        .op_valid   (op_valid),
        .equal      (equal),
        .busy       (busy),
        .complete   (complete),
        .display    (display),
        .as_a       (as_a),
        .as_b       (as_b),
        .as_sub     (as_sub),
        .as_start   (as_start),
        .as_result  (as_result),
        .as_done    (as_done),
        .mul_a      (mul_a),
        .mul_b      (mul_b),
        .mul_start  (mul_start),
        .mul_result (mul_result),
        .mul_done   (mul_done)
    );

    add_sub_unit #(.SLICE_WIDTH(4)) u_add_sub (
        .clk       (clk),
        .nRST      (nRST),
        .as_start  (as_start),
        .as_a      (as_a),
        .as_b      (as_b),
        .as_sub    (as_sub),
        .as_result (as_result),
        .as_done   (as_done)
    );

    shift_add_multiplier u_mul (
        .clk        (clk),
        .nRST       (nRST),
        .mul_start  (mul_start),
        .mul_a      (mul_a),
        .mul_b      (mul_b),
        .mul_result (mul_result),
        .mul_done   (mul_done)
    );

endmodule

/* src/shift_add_multiplier.sv */
module shift_add_multiplier import calc_pkg::*; (
    input  logic  clk,
    input  logic  nRST,
    input  logic  mul_start,
    input  word_t mul_a,
    input  word_t mul_b,
    output word_t mul_result,
    output logic  mul_done
);
    word_t acc_q, mcand_q, mplier_q;
    word_t acc_in, mcand_in, mplier_in;
    word_t acc_next, mplier_next;
    logic  active_q, done_q;
    logic  step;

    // First step runs in the start cycle on the raw inputs
    always_comb begin
        acc_in    = mul_start ? '0 : acc_q;
        mcand_in  = mul_start ? mul_a : mcand_q;
        mplier_in = mul_start ? mul_b : mplier_q;

        if (mplier_in[0])
            acc_next = acc_in + mcand_in;      // Partial product, wraps
        else
            acc_next = acc_in;

        mplier_next = mplier_in >> 1;
    end

    assign step = mul_start || active_q;

    // Stop as soon as no multiplier bits are left
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            active_q <= 1'b0;
            done_q   <= 1'b0;
        end else begin
            active_q <= step && (mplier_next != '0);
            done_q   <= step && (mplier_next == '0);
        end
    end

    always_ff @(posedge clk) begin
        if (step) begin
            acc_q    <= acc_next;
            mcand_q  <= mcand_in << 1;         // Upper bits fall off
            mplier_q <= mplier_next;
        end
    end

    assign mul_result = acc_q;                 // Low 16 bits of product
    assign mul_done   = done_q;

endmodule

/* verif/calc_checker.sv */
`include "calc_defines.svh"

module calc_checker import calc_pkg::*; (
    input  logic   clk,
    input  logic   nRST,
    input  digit_t key_digit,
    input  logic   key_valid,
    input  op_t    op_code,
    input  logic   op_valid,
    input  logic   equal,
    input  logic   busy,
    input  logic   complete,
    input  word_t  display,
    input  word_t  table_expect,
    output int     pass_count,
    output int     fail_count
);
    timeunit 1ns;
    timeprecision 1ps;

    word_t opnd_a, opnd_b, expect_q;
    op_t   op_m;
    logic  second;                             // Entering the second operand
    logic  pending;                            // Equal taken, result not seen yet
    logic  reset_seen;
    int    test_num;
    bit    ok;

    function automatic bit one_hot(op_t code);
        return (code != '0) && ((code & (code - 1'b1)) == '0);
    endfunction

    function automatic word_t model_result(word_t a, word_t b, op_t op);
        case (op)
            `OP_SUB: return a - b;             // Wraps below zero
            `OP_MUL: return a * b;             // Low 16 bits only
            default: return a + b;
        endcase
    endfunction

    function automatic bit compare_word(string name, word_t expv, word_t got);
        if (expv !== got) begin
            $display("error %s expected 0x%h got 0x%h", name, expv, got);
            return 1'b0;
        end
        return 1'b1;
    endfunction

    task automatic finish_test(string what, bit good);
        if (good) begin
            pass_count++;
            $display("test %0d %s ok", test_num, what);
        end else begin
            fail_count++;
            $display("test %0d %s failed", test_num, what);
        end
        test_num++;
    endtask

    always @(posedge clk) begin
        if (!nRST) begin
            opnd_a     = '0;
            opnd_b     = '0;
            second     = 1'b0;
            pending    = 1'b0;
            reset_seen = 1'b0;
        end else begin
            if (!reset_seen) begin
                ok = compare_word("display", '0, display);
                ok = compare_word("busy", '0, word_t'(busy)) && ok;
                ok = compare_word("complete", '0, word_t'(complete)) && ok;
                finish_test("reset", ok);
                reset_seen = 1'b1;
            end
            if (complete) begin
                if (pending) begin
                    ok = compare_word("display", expect_q, display);
                    if (expect_q !== table_expect) begin
                        $display("model value 0x%h and table value 0x%h disagree",
                                 expect_q, table_expect);
                        ok = 1'b0;
                    end
                end else begin
                    $display("complete pulsed with no operation pending");
                    ok = 1'b0;
                end
                pending = 1'b0;
                finish_test("result", ok);
            end
            // Inputs count only while the core is idle
            if (!busy) begin
                if (key_valid && key_digit <= `MAX_DIGIT) begin
                    if (second)
                        opnd_b = opnd_b * 16'd10 + word_t'(key_digit);
                    else
                        opnd_a = opnd_a * 16'd10 + word_t'(key_digit);
                end else if (op_valid && one_hot(op_code) && !second) begin
                    op_m   = op_code;
                    second = 1'b1;
                end else if (equal && second) begin
                    expect_q = model_result(opnd_a, opnd_b, op_m);
                    pending  = 1'b1;
                    second   = 1'b0;
                    opnd_a   = '0;
                    opnd_b   = '0;
                end
            end
        end
    end

endmodule

/* verif/calc_properties.sv */
module calc_properties (
    input logic clk,
    input logic nRST,
    input logic busy,
    input logic complete,
    input logic as_start,
    input logic mul_start
);
    timeunit 1ns;
    timeprecision 1ps;

    int violations;                            // Failure count seen by the testbench

    // Result strobe lasts exactly one cycle
    complete_one_cycle: assert property (
        @(posedge clk) disable iff (!nRST) complete |=> !complete
    ) else begin
        $error("complete high for two consecutive cycles");
        violations++;
    end

    // Only one arithmetic unit in flight
    start_exclusive: assert property (
        @(posedge clk) disable iff (!nRST) !(as_start && mul_start)
    ) else begin
        $error("as_start and mul_start high together");
        violations++;
    end

    idle_on_complete: assert property (
        @(posedge clk) disable iff (!nRST) complete |-> !busy
    ) else begin
        $error("busy high while complete is high");
        violations++;
    end

endmodule

bind calc_controller calc_properties u_props (
    .clk       (clk),
    .nRST      (nRST),
    .busy      (busy),
    .complete  (complete),
    .as_start  (as_start),
    .mul_start (mul_start)
);

/* verif/tb_calc.sv */
`include "calc_defines.svh"

module tb_calc import calc_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_ENTRIES = 10;
    localparam int CYCLE_LIMIT = NUM_ENTRIES * 400;

    logic   clk, nRST;
    digit_t key_digit;
    logic   key_valid, op_valid, equal;
    op_t    op_code;
    logic   busy, complete;
    word_t  display, table_expect;
    int     pass_count, fail_count;
    int     cycles, tb_errors, failed;

    // Digits are hex nibbles, most significant entered first
    logic [19:0] a_digits    [NUM_ENTRIES];
    int          a_len       [NUM_ENTRIES];
    op_t         op_list     [NUM_ENTRIES];
    logic [19:0] b_digits    [NUM_ENTRIES];
    int          b_len       [NUM_ENTRIES];
    logic [2:0]  inject      [NUM_ENTRIES]; // Bad digit, bad op, key while busy
    word_t       expect_list [NUM_ENTRIES];

    calc_top dut (.*);

    calc_checker u_checker (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("run timed out after %0d cycles with a test still pending", cycles);
            $display("TESTS FAILED");
            $finish;
        end
    end

    task automatic set_entry(int idx, logic [19:0] ad, int al, op_t op,
                             logic [19:0] bd, int bl, logic [2:0] inj, word_t res);
        a_digits[idx]    = ad;
        a_len[idx]       = al;
        op_list[idx]     = op;
        b_digits[idx]    = bd;
        b_len[idx]       = bl;
        inject[idx]      = inj;
        expect_list[idx] = res;
    endtask

    task automatic wait_idle();
        while (busy) @(negedge clk);
    endtask

    task automatic press_digit(digit_t d);
        wait_idle();
        key_digit = d;
        key_valid = 1'b1;
        @(negedge clk);
        key_valid = 1'b0;
    endtask

    task automatic press_op(op_t code);
        wait_idle();
        op_code  = code;
        op_valid = 1'b1;
        @(negedge clk);
        op_valid = 1'b0;
    endtask

    task automatic press_equal();
        wait_idle();
        equal = 1'b1;
        @(negedge clk);
        equal = 1'b0;
    endtask

    task automatic enter_operand(logic [19:0] digits, int len, bit bad_digit, bit while_busy);
        for (int i = len - 1; i >= 0; i--) begin
            if (bad_digit && i == 0)
                press_digit(4'hc);             // Above nine, dropped
            press_digit(digits[i*4 +: 4]);
            if (while_busy && i == len - 1) begin
                if (!busy) begin
                    $display("busy stayed low after an accepted digit");
                    tb_errors++;
                end
                key_digit = 4'd7;
                key_valid = 1'b1;
                @(negedge clk);
                key_valid = 1'b0;
            end
        end
    endtask

    initial begin
        nRST         = 1'b0;
        key_digit    = '0;
        key_valid    = 1'b0;
        op_code      = '0;
        op_valid     = 1'b0;
        equal        = 1'b0;
        table_expect = '0;
        cycles       = 0;
        tb_errors    = 0;

        set_entry(0, 20'h01234, 4, `OP_ADD, 20'h00058, 2, 3'b000, 16'h050c);
        set_entry(1, 20'h65000, 5, `OP_ADD, 20'h00600, 3, 3'b000, 16'h0040);
        set_entry(2, 20'h00500, 3, `OP_SUB, 20'h00123, 3, 3'b000, 16'h0179);
        set_entry(3, 20'h00012, 2, `OP_SUB, 20'h00345, 3, 3'b000, 16'hfeb3);
        set_entry(4, 20'h00789, 3, `OP_MUL, 20'h00000, 1, 3'b000, 16'h0000);
        set_entry(5, 20'h00123, 3, `OP_MUL, 20'h00007, 1, 3'b000, 16'h035d);
        set_entry(6, 20'h00300, 3, `OP_MUL, 20'h00400, 3, 3'b000, 16'hd4c0);
        set_entry(7, 20'h99999, 5, `OP_ADD, 20'h00001, 1, 3'b000, 16'h86a0);
        set_entry(8, 20'h00500, 3, `OP_SUB, 20'h00123, 3, 3'b011, 16'h0179);
        set_entry(9, 20'h00042, 2, `OP_SUB, 20'h00017, 2, 3'b100, 16'h0019);

        repeat (4) @(posedge clk);
        @(negedge clk);
        nRST = 1'b1;
        @(negedge clk);                        // Idle cycle for the reset check

        for (int t = 0; t < NUM_ENTRIES; t++) begin
            table_expect = expect_list[t];
            enter_operand(a_digits[t], a_len[t], inject[t][0], inject[t][2]);
            if (inject[t][1])
                press_op(3'b011);              // Not one-hot, dropped
            press_op(op_list[t]);
            enter_operand(b_digits[t], b_len[t], 1'b0, 1'b0);
            press_equal();
            while (!complete) @(negedge clk);
            @(negedge clk);
        end
        repeat (2) @(negedge clk);

        if (pass_count + fail_count != NUM_ENTRIES + 1) begin
            $display("only %0d of %0d tests reported a result",
                     pass_count + fail_count, NUM_ENTRIES + 1);
            tb_errors++;
        end
        failed = fail_count + tb_errors + dut.u_ctrl.u_props.violations;
        $display("passed %0d, failed %0d", pass_count, failed);
        if (failed == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
